// File: design/iCacheArray.sv
`timescale 1ns/1ps

module iCacheArray #(
	parameter int numSets = iCachePkg::numSetsDefault,
	parameter int wordsPerBlock = iCachePkg::wordsPerBlockDefault
) (
	input  logic                                   CLK,
	input  logic                                   RST,
	input  logic                                   flush,
	input  logic                                   lookupEn,
	input  logic [iCachePkg::addrWidth-1:0]        lookupAddr,
	input  logic                                   fillWe,
	input  logic [$clog2(numSets)-1:0]             fillIndex,
	input  logic [$clog2(wordsPerBlock)-1:0]       fillOffset,
	input  logic [iCachePkg::addrWidth-$clog2(numSets)-$clog2(wordsPerBlock)
		-iCachePkg::byteBits-1:0]                  fillTag,
	input  logic [iCachePkg::dataWidth-1:0]        fillData,
	output logic                                   hit,
	output logic [iCachePkg::dataWidth-1:0]        lineData
);

	import iCachePkg::*;

	localparam int indexBits = $clog2(numSets);
	localparam int offBits = $clog2(wordsPerBlock);
	localparam int tagBits = addrWidth - indexBits - offBits - byteBits;

	logic [tagBits-1:0]   tagMem [numSets];
	logic [dataWidth-1:0] dataMem [numSets*wordsPerBlock];
	logic [numSets-1:0]   validBits;

	logic [indexBits-1:0] lookIndex;
	logic [offBits-1:0]   lookOffset;
	logic [tagBits-1:0]   lookTag;

	// split the fetch address
	assign lookOffset = lookupAddr[byteBits +: offBits];
	assign lookIndex = lookupAddr[byteBits+offBits +: indexBits];
	assign lookTag = lookupAddr[addrWidth-1 -: tagBits];

	// tag and data written with every refill word
	always_ff @(posedge CLK) begin
		if (fillWe) begin
			dataMem[{fillIndex, fillOffset}] <= fillData;
			tagMem[fillIndex] <= fillTag;
		end
	end

	// a set turns valid only once its last word is in,
	// the first word of a refill drops the old block
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			validBits <= '0;
		end else if (flush) begin
			validBits <= '0;
		end else if (fillWe) begin
			validBits[fillIndex] <= (fillOffset == offBits'(wordsPerBlock - 1));
		end
	end

	// registered lookup
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			hit <= 1'b0;
		end else if (lookupEn) begin
			hit <= validBits[lookIndex] && (tagMem[lookIndex] == lookTag);
		end
	end

	always_ff @(posedge CLK) begin
		if (lookupEn) begin
			lineData <= dataMem[{lookIndex, lookOffset}];
		end
	end

endmodule

// File: design/iCacheControl.sv
`timescale 1ns/1ps

module iCacheControl (
	input  logic                             CLK,
	input  logic                             RST,
	input  logic                             fetchEn,
	input  logic [iCachePkg::addrWidth-1:0]  fetchAddr,
	input  logic                             hit,
	input  logic [iCachePkg::dataWidth-1:0]  lineData,
	input  logic                             fillDone,
	output logic                             lookupEn,
	output logic                             refillStart,
	output logic [iCachePkg::addrWidth-1:0]  refillBase,
	output logic [iCachePkg::dataWidth-1:0]  fetchData,
	output logic                             ready,
	output logic                             stall
);

	import iCachePkg::*;

	localparam int blockBits = offsetWidth + byteBits;

	ctrlState state;
	ctrlState nextState;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	// word is delivered while the registered lookup shows a hit
	assign ready = (state == stRead) && hit;

	// stall covers the refill start cycle and the wait for the block
	assign stall = (state == stFill) || (state == stMiss);

	assign refillStart = (state == stFill); // single cycle pulse

	// block aligned base of the missing fetch
	assign refillBase = {fetchAddr[addrWidth-1:blockBits], {blockBits{1'b0}}};

	assign fetchData = ready ? lineData : '0;

	// array lookup strobe
	// in stRead a hit frees the port, so a new address is taken at once
	always_comb begin
		lookupEn = 1'b0;
		case (state)
			stIdle: begin
				lookupEn = fetchEn;
			end
			stRead: begin
				lookupEn = fetchEn && hit; // streaming hits
			end
			stMiss: begin
				lookupEn = fillDone; // block stored, look again
			end
			default: begin
				lookupEn = 1'b0;
			end
		endcase
	end

	// next state
	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (fetchEn) begin
					nextState = stRead;
				end
			end
			stRead: begin
				if (!hit) begin
					nextState = stFill;     // miss, start the refill
				end else if (fetchEn) begin
					nextState = stRead;     // next word already presented
				end else begin
					nextState = stIdle;
				end
			end
			stFill: begin
				nextState = stMiss;
			end
			stMiss: begin
				if (fillDone) begin
					nextState = stRead;
				end
			end
			default: begin
				nextState = stIdle;
			end
		endcase
	end

endmodule

// File: design/iCachePkg.sv
package iCachePkg;

	// address and word sizes
	localparam int addrWidth = 32;
	localparam int dataWidth = 32;

	// address split: tag 31:12, index 11:5, offset 4:2, byte 1:0
	localparam int tagWidth = 20;
	localparam int indexWidth = 7;
	localparam int offsetWidth = 3;
	localparam int byteBits = addrWidth - tagWidth - indexWidth - offsetWidth;

	// block geometry
	localparam int numSetsDefault = 1 << indexWidth;        // 128 sets
	localparam int wordsPerBlockDefault = 1 << offsetWidth; // 8 words per block

	// controller states
	typedef enum logic [1:0] {
		stIdle = 2'b00,
		stRead = 2'b01,
		stMiss = 2'b10,
		stFill = 2'b11
	} ctrlState;

endpackage

// File: design/iCacheRefill.sv
`timescale 1ns/1ps

module iCacheRefill #(
	parameter int wordsPerBlock = iCachePkg::wordsPerBlockDefault
) (
	input  logic                                   CLK,
	input  logic                                   RST,
	input  logic                                   refillStart,
	input  logic [iCachePkg::addrWidth-1:0]        refillBase,
	input  logic                                   memValid,
	input  logic [iCachePkg::dataWidth-1:0]        memData,
	output logic                                   memReq,
	output logic [iCachePkg::addrWidth-1:0]        memAddr,
	output logic                                   fillWe,
	output logic [iCachePkg::indexWidth-1:0]       fillIndex,
	output logic [$clog2(wordsPerBlock)-1:0]       fillOffset,
	output logic [iCachePkg::addrWidth-iCachePkg::indexWidth-$clog2(wordsPerBlock)
		-iCachePkg::byteBits-1:0]                  fillTag,
	output logic [iCachePkg::dataWidth-1:0]        fillData,
	output logic                                   fillDone
);

	import iCachePkg::*;

	localparam int offBits = $clog2(wordsPerBlock);
	localparam int blockNumBits = addrWidth - offBits - byteBits;

	logic                    busy;
	logic [offBits-1:0]      count;    // word being fetched
	logic [blockNumBits-1:0] blockNum; // address bits above the block
	logic                    lastWord;

	assign lastWord = (count == offBits'(wordsPerBlock - 1));

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			busy <= 1'b0;
			count <= '0;
			memReq <= 1'b0;
			fillDone <= 1'b0;
		end else begin
			memReq <= refillStart || (busy && memValid && !lastWord); // next word after valid
			fillDone <= busy && memValid && lastWord;
			if (refillStart) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy && memValid) begin
				count <= count + 1'b1;
				if (lastWord) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (refillStart) begin
			blockNum <= refillBase[addrWidth-1:offBits+byteBits];
		end
	end

	assign memAddr = {blockNum, count, {byteBits{1'b0}}}; // base plus four times count

	// each returned word goes straight into the array
	assign fillWe = busy && memValid;
	assign fillData = memData;
	assign fillOffset = count;
	assign fillIndex = blockNum[indexWidth-1:0];
	assign fillTag = blockNum[blockNumBits-1:indexWidth];

endmodule

// File: design/iCacheTop.sv
`timescale 1ns/1ps

module iCacheTop #(
	parameter int numSets = iCachePkg::numSetsDefault,
	parameter int wordsPerBlock = iCachePkg::wordsPerBlockDefault
) (
	input  logic                             CLK,
	input  logic                             RST,
	input  logic                             fetchEn,
	input  logic [iCachePkg::addrWidth-1:0]  fetchAddr,
	input  logic                             flush,
	input  logic [iCachePkg::dataWidth-1:0]  memData,
	input  logic                             memValid,
	output logic [iCachePkg::dataWidth-1:0]  fetchData,
	output logic                             ready,
	output logic                             stall,
	output logic                             memReq,
	output logic [iCachePkg::addrWidth-1:0]  memAddr
);

	import iCachePkg::*;

	localparam int offBits = $clog2(wordsPerBlock);

	// control to array and refill
	logic                 lookupEn;
	logic                 hit;
	logic [dataWidth-1:0] lineData;
	logic                 refillStart;
	logic [addrWidth-1:0] refillBase;

	// refill write path into the array
	logic                                          fillWe;
	logic [indexWidth-1:0]                         fillIndex;
	logic [offBits-1:0]                            fillOffset;
	logic [addrWidth-indexWidth-offBits-byteBits-1:0] fillTag;
	logic [dataWidth-1:0]                          fillData;
	logic                                          fillDone;

	iCacheControl control0 (
		.CLK        (CLK),
		.RST        (RST),
		.fetchEn    (fetchEn),
		.fetchAddr  (fetchAddr),
		.hit        (hit),
		.lineData   (lineData),
		.fillDone   (fillDone),
		.lookupEn   (lookupEn),
		.refillStart(refillStart),
		.refillBase (refillBase),
		.fetchData  (fetchData),
		.ready      (ready),
		.stall      (stall)
	);

	iCacheArray #(.numSets(numSets), .wordsPerBlock(wordsPerBlock)) array0 (
		.CLK       (CLK),
		.RST       (RST),
		.flush     (flush),
		.lookupEn  (lookupEn),
		.lookupAddr(fetchAddr),
		.fillWe    (fillWe),
		.fillIndex (fillIndex),
		.fillOffset(fillOffset),
		.fillTag   (fillTag),
		.fillData  (fillData),
		.hit       (hit),
		.lineData  (lineData)
	);

	iCacheRefill #(.wordsPerBlock(wordsPerBlock)) refill0 (
		.CLK        (CLK),
		.RST        (RST),
		.refillStart(refillStart),
		.refillBase (refillBase),
		.memValid   (memValid),
		.memData    (memData),
		.memReq     (memReq),
		.memAddr    (memAddr),
		.fillWe     (fillWe),
		.fillIndex  (fillIndex),
		.fillOffset (fillOffset),
		.fillTag    (fillTag),
		.fillData   (fillData),
		.fillDone   (fillDone)
	);

endmodule

// File: list.f
design/iCachePkg.sv
design/iCacheControl.sv
design/iCacheArray.sv
design/iCacheRefill.sv
design/iCacheTop.sv
verif/instrMemModel.sv
verif/iCacheProperties.sv
verif/iCacheTb.sv

// File: verif/iCacheProperties.sv
`timescale 1ns/1ps

module iCacheProperties (
	input logic                            CLK,
	input logic                            RST,
	input iCachePkg::ctrlState             state,
	input logic                            memReq,
	input logic                            memValid,
	input logic                            ready,
	input logic                            stall,
	input logic [iCachePkg::dataWidth-1:0] fetchData
);

	import iCachePkg::*;

	logic outstanding; // request sent, word not back yet

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			outstanding <= 1'b0;
		end else if (memReq) begin
			outstanding <= 1'b1;
		end else if (memValid) begin
			outstanding <= 1'b0;
		end
	end

	singleRequest: assert property (@(posedge CLK) disable iff (!RST)
		memReq |-> !outstanding)
		else $error("memReq issued while a memory request is outstanding");

	// overlap only allowed in the cycle stall drops
	readyStall: assert property (@(posedge CLK) disable iff (!RST)
		(ready && stall) |=> !stall)
		else $error("ready and stall high together with stall staying up");

	idleData: assert property (@(posedge CLK) disable iff (!RST)
		!ready |-> fetchData == '0)
		else $error("fetchData not zero while ready is low");

	reqWhileMiss: assert property (@(posedge CLK) disable iff (!RST)
		memReq |-> state == stMiss)
		else $error("memReq while the controller is not waiting on a refill");

endmodule

// File: verif/iCacheTb.sv
`timescale 1ns/1ps

module iCacheTb;

	import iCachePkg::*;

	localparam int maxVectors = 64;
	localparam int vecWords = 3;     // op, address, expected word
	localparam int blockWords = 8;
	localparam int latMin = 1;
	localparam int latMax = 6;
	localparam int latSeed = 32'h9bc2;
	localparam int opFlush = 0;
	localparam int opMiss = 1;
	localparam int opStream = 3;     // 2 is a hit started from idle

	logic                 CLK;
	logic                 RST;
	logic                 fetchEn;
	logic [addrWidth-1:0] fetchAddr;
	logic                 flush;
	logic [dataWidth-1:0] memData;
	logic                 memValid;
	logic [dataWidth-1:0] fetchData;
	logic                 ready;
	logic                 stall;
	logic                 memReq;
	logic [addrWidth-1:0] memAddr;

	logic [31:0] vecMem [maxVectors*vecWords];
	int numVectors;
	int cycleCount = 0;
	int timeoutLimit;
	int checkCount;
	int valueErrors;
	int otherErrors;

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	iCacheTop #(.numSets(numSetsDefault), .wordsPerBlock(wordsPerBlockDefault)) dut0 (
		.CLK      (CLK),
		.RST      (RST),
		.fetchEn  (fetchEn),
		.fetchAddr(fetchAddr),
		.flush    (flush),
		.memData  (memData),
		.memValid (memValid),
		.fetchData(fetchData),
		.ready    (ready),
		.stall    (stall),
		.memReq   (memReq),
		.memAddr  (memAddr)
	);

	instrMemModel #(.latMin(latMin), .latMax(latMax), .seed(latSeed)) mem0 (
		.CLK     (CLK),
		.RST     (RST),
		.memReq  (memReq),
		.memAddr (memAddr),
		.memData (memData),
		.memValid(memValid)
	);

	bind iCacheTop iCacheProperties props0 (
		.CLK      (CLK),
		.RST      (RST),
		.state    (control0.state),
		.memReq   (memReq),
		.memValid (memValid),
		.ready    (ready),
		.stall    (stall),
		.fetchData(fetchData)
	);

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic nextCycle();
		@(posedge CLK);
		#2; // outputs of this edge have settled
	endtask

	task automatic compareWord(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			valueErrors++;
			$display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	// tag and index kept, offset and byte bits cleared
	function automatic logic [31:0] blockBase(input logic [31:0] addr);
		return {addr[31:5], 5'b0};
	endfunction

	// request already on the port, wait for its word
	task automatic runFetch(input int idx);
		logic [31:0] op;
		logic [31:0] addr;
		string testName;
		int waited;
		int reqCount;
		bit sawStall;
		op = vecMem[idx*vecWords];
		addr = vecMem[idx*vecWords+1];
		testName = $sformatf("vector %0d at %h", idx, addr);
		waited = 0;
		reqCount = 0;
		sawStall = 1'b0;
		do begin
			nextCycle();
			waited++;
			if (memReq) begin
				compareWord({testName, " memAddr"}, blockBase(addr) + 4 * reqCount, memAddr);
				reqCount++;
			end
			if (stall) begin
				sawStall = 1'b1;
			end
		end while (!ready);
		compareWord({testName, " data"}, vecMem[idx*vecWords+2], fetchData);
		compareWord({testName, " stall with ready"}, 0, stall);
		if (op == opMiss) begin
			compareWord({testName, " stall seen"}, 1, sawStall);
			compareWord({testName, " memReq count"}, blockWords, reqCount);
		end else begin
			compareWord({testName, " hit latency"}, 1, waited);
			compareWord({testName, " stall seen"}, 0, sawStall);
			compareWord({testName, " memReq count"}, 0, reqCount);
		end
	endtask

	initial begin
		int idx;
		RST = 1'b0;
		fetchEn = 1'b0;
		fetchAddr = '0;
		flush = 1'b0;
		checkCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		for (int i = 0; i < maxVectors * vecWords; i++) begin
			vecMem[i] = 'x;
		end
		$readmemh("verif/iCacheVectors.txt", vecMem);
		numVectors = 0;
		while (numVectors < maxVectors && !$isunknown(vecMem[numVectors*vecWords])) begin
			numVectors++;
		end
		timeoutLimit = 40 * numVectors + 200;
		assert (numVectors > 0) else begin
			otherErrors++;
			$display("no vectors could be read from verif/iCacheVectors.txt");
		end

		repeat (2) @(posedge CLK);
		#2;
		RST = 1'b1;
		compareWord("reset ready", 0, ready);
		compareWord("reset stall", 0, stall);
		compareWord("reset memReq", 0, memReq);

		idx = 0;
		while (idx < numVectors) begin
			if (vecMem[idx*vecWords] == opFlush) begin
				nextCycle();
				flush = 1'b1;
				nextCycle();
				flush = 1'b0;
			end else begin
				if (!fetchEn) begin
					nextCycle();
					fetchEn = 1'b1;
					fetchAddr = vecMem[idx*vecWords+1];
				end
				runFetch(idx);
				// next address goes out in the ready cycle when streaming
				if (idx + 1 < numVectors && vecMem[(idx+1)*vecWords] == opStream) begin
					fetchAddr = vecMem[(idx+1)*vecWords+1];
				end else begin
					fetchEn = 1'b0;
				end
			end
			idx++;
		end
		repeat (4) nextCycle();

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checkCount, valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: verif/iCacheVectors.txt
// op address expected, all hex
// op 0 flush, 1 fetch that misses, 2 fetch that hits, 3 hit streamed after the previous line
1 00001048 A5A50412
2 00001040 A5A50410
2 0000105C A5A50417
2 00001044 A5A50411
3 0000104C A5A50413
3 00001050 A5A50414
3 00001054 A5A50415
3 00001058 A5A50416
1 00023050 A5A58C14
2 00023044 A5A58C11
1 00001048 A5A50412
0 00000000 00000000
1 00001040 A5A50410
2 0000105C A5A50417
1 80000FE4 85A503F9
2 80000FFC 85A503FF
3 80000FE0 85A503F8

// File: verif/instrMemModel.sv
`timescale 1ns/1ps

module instrMemModel #(
	parameter int latMin = 1,
	parameter int latMax = 6,
	parameter int seed = 1
) (
	input  logic        CLK,
	input  logic        RST,
	input  logic        memReq,
	input  logic [31:0] memAddr,
	output logic [31:0] memData,
	output logic        memValid
);

	logic [31:0] heldAddr;
	int          remain;  // cycles left until the word returns
	bit          pending;

	// word address folded with a fixed pattern
	function automatic logic [31:0] wordAt(input logic [31:0] addr);
		return (addr >> 2) ^ 32'hA5A5_0000;
	endfunction

	initial begin
		memValid = 1'b0;
		memData = '0;
		heldAddr = '0;
		remain = 0;
		pending = 1'b0;
		void'($urandom(seed));
		forever begin
			@(posedge CLK);
			#2;
			memValid = 1'b0; // one cycle strobe
			if (!RST) begin
				pending = 1'b0;
			end else begin
				if (pending) begin
					remain--;
					if (remain == 0) begin
						memValid = 1'b1;
						memData = wordAt(heldAddr);
						pending = 1'b0;
					end
				end
				if (memReq) begin
					heldAddr = memAddr;
					remain = $urandom_range(latMax, latMin);
					pending = 1'b1;
				end
			end
		end
	end

endmodule
